/* design/lsi_pkg.sv */
// shared definitions for the LSI-11 board logic
// phase enables, extra microinstruction strobe codes, bus timer limit
// chipset-side and Q-bus side signal bundles
`default_nettype none

package lsi_pkg;

   // one-hot phase enables, one c2 cycle each
   typedef struct packed {
      logic ph1;                       // rply sample, iako, dma request
      logic ph2;                       // interrupt register, sr, dout_d
      logic ph3;                       // strobes, sync/dout, timer tick
      logic ph4;                       // dma acknowledge/grant
   } phase_t;

   // phase counter values
   localparam logic [1:0] PH1_CNT = 2'd0;
   localparam logic [1:0] PH2_CNT = 2'd1;
   localparam logic [1:0] PH3_CNT = 2'd2;
   localparam logic [1:0] PH4_CNT = 2'd3;

   typedef logic [3:0] mc_code_t;      // extra microinstruction bits

   // housekeeping strobe codes, 1000 and below are no-ops
   localparam mc_code_t MC_CLR_INIT = 4'b1001;   // drop peripheral init
   localparam mc_code_t MC_CLR_BERR = 4'b1010;   // clear bus error and refresh
   localparam mc_code_t MC_SET_RFSH = 4'b1011;   // set refresh flag
   localparam mc_code_t MC_SET_INIT = 4'b1100;   // raise peripheral init
   localparam mc_code_t MC_SET_FDIN = 4'b1101;   // fast input read
   localparam mc_code_t MC_CLR_ACLO = 4'b1110;   // ack power-fail request
   localparam mc_code_t MC_CLR_EVNT = 4'b1111;   // ack timer request

   localparam logic [5:0] QTIM_MAX = 6'd63;      // bus timeout in ph3 periods

   // chipset toward board
   typedef struct packed {
      logic        syn;                // address strobe
      logic        di;                 // data in
      logic        dout;               // data out
      logic        inrak;              // interrupt ack
      logic        wrby;               // write/byte
      logic [15:0] ad;                 // address/data from chipset
   } core_bus_t;

   // board back to chipset
   typedef struct packed {
      logic [3:0]  inrrq;              // refresh, power/halt, event, virq
      logic        bbusy;              // bus busy
      logic        sr;                 // microcode reset
      logic        ra;                 // reply
      logic [15:0] ad_rd;              // read data
   } core_ctl_t;

   typedef struct packed {
      logic        rply;
      logic        sack;
      logic        dmr;
      logic        rfrq;
      logic [15:0] ad;
   } qbus_in_t;

   typedef struct packed {
      logic [15:0] ad;
      logic        ad_oe;
      logic        sync;
      logic        wtbt;
      logic        dout;
      logic        din;
      logic        ctrl_oe;            // enable for sync/wtbt/dout/din
      logic        iako;
      logic        init;
      logic        dmgo;
      logic        dref;
   } qbus_out_t;

endpackage

`default_nettype wire

/* design/lsi_sequencer.sv */
// four-phase enable generator
// extra microinstruction bit decoder into ph3 strobes
`timescale 1ns/100ps
`default_nettype none

module lsi_sequencer
(
   input  wire                c2,
   input  wire                dclo,
   input  lsi_pkg::mc_code_t  mc,         // extra microinstruction bits
   output lsi_pkg::phase_t    ph,         // registered one-hot phases
   output logic               clr_init,
   output logic               clr_berr,
   output logic               set_rfsh,
   output logic               set_init,
   output logic               set_fdin,
   output logic               clr_aclo,
   output logic               clr_evnt
);
   import lsi_pkg::*;

   logic [1:0] ccnt;                      // phase counter

   always_ff @(posedge c2 or posedge dclo)
   begin
      if (dclo)
      begin
         ccnt <= PH1_CNT;
         ph   <= '0;                      // no phase during reset
      end
      else
      begin
         ccnt   <= ccnt + 2'd1;
         ph.ph1 <= (ccnt == PH1_CNT);
         ph.ph2 <= (ccnt == PH2_CNT);
         ph.ph3 <= (ccnt == PH3_CNT);
         ph.ph4 <= (ccnt == PH4_CNT);
      end
   end

   // strobes only fire in ph3 with the code present
   assign clr_init = ph.ph3 & (mc == MC_CLR_INIT);
   assign clr_berr = ph.ph3 & (mc == MC_CLR_BERR);
   assign set_rfsh = ph.ph3 & (mc == MC_SET_RFSH);
   assign set_init = ph.ph3 & (mc == MC_SET_INIT);
   assign set_fdin = ph.ph3 & (mc == MC_SET_FDIN);
   assign clr_aclo = ph.ph3 & (mc == MC_CLR_ACLO);
   assign clr_evnt = ph.ph3 & (mc == MC_CLR_EVNT);

endmodule

`default_nettype wire

/* design/lsi_events.sv */
// power-fail and timer edge detectors, sticky requests
// peripheral init flag, refresh flag and request
// interrupt request register and microcode reset
`timescale 1ns/100ps
`default_nettype none

module lsi_events
(
   input  wire              c2,
   input  wire              dclo,
   input  lsi_pkg::phase_t  ph,
   input  wire              clr_init,
   input  wire              set_init,
   input  wire              set_rfsh,
   input  wire              clr_berr,
   input  wire              clr_aclo,
   input  wire              clr_evnt,
   input  wire              aclo,       // power fail notice
   input  wire              evnt,       // line clock
   input  wire              halt,
   input  wire              virq,       // vectored interrupt level
   input  wire              rfrq,       // refresh request line
   input  wire              berr_rq,    // timeout abort from bus timer
   output logic [3:0]       inrrq,
   output logic             sr,
   output logic             init_st,
   output logic             dref_st,
   output logic             dref_rq,
   output logic             aclo_any
);
   import lsi_pkg::*;

   logic aclo_d, evnt_d, rfrq_d;          // edge detector history
   logic aclo_rq, evnt_rq;                // sticky requests

   always_ff @(posedge c2 or posedge dclo)
   begin
      if (dclo)
      begin
         aclo_d  <= 1'b0;
         evnt_d  <= 1'b0;
         rfrq_d  <= 1'b0;
         aclo_rq <= 1'b0;
         evnt_rq <= 1'b0;
         dref_rq <= 1'b0;
      end
      else
      begin
         aclo_d <= aclo;
         evnt_d <= evnt;
         rfrq_d <= rfrq;
         if (clr_aclo)
            aclo_rq <= 1'b0;              // ack wins over a new edge
         else if (aclo & ~aclo_d)
            aclo_rq <= 1'b1;
         if (clr_evnt)
            evnt_rq <= 1'b0;
         else if (evnt & ~evnt_d)
            evnt_rq <= 1'b1;
         if (set_rfsh)
            dref_rq <= 1'b0;              // refresh taken by microcode
         else if (rfrq & ~rfrq_d)
            dref_rq <= 1'b1;
      end
   end

   // init and refresh flags under microcode control
   always_ff @(posedge c2 or posedge dclo)
   begin
      if (dclo)
      begin
         init_st <= 1'b1;                 // peripherals held in reset
         dref_st <= 1'b0;
      end
      else
      begin
         if (clr_init)
            init_st <= 1'b0;
         else if (set_init)
            init_st <= 1'b1;
         if (set_rfsh)
            dref_st <= 1'b1;
         else if (clr_berr)
            dref_st <= 1'b0;
      end
   end

   // interrupt register and cycle abort, both at ph2
   always_ff @(posedge c2 or posedge dclo)
   begin
      if (dclo)
      begin
         inrrq <= 4'b0000;
         sr    <= 1'b1;                   // chipset starts in reset
      end
      else if (ph.ph2)
      begin
         inrrq <= {dref_rq, aclo_rq | halt, evnt_rq, virq};
         sr    <= berr_rq;
      end
   end

   assign aclo_any = aclo | aclo_rq;      // power status for fast read

endmodule

`default_nettype wire

/* design/lsi_qbus.sv */
// Q-bus data cycle sequencing: sync, dout, din, reply, iako
// fast-input flag and read data path
// address/data and control drive enables
`timescale 1ns/100ps
`default_nettype none

module lsi_qbus
(
   input  wire                 c2,
   input  wire                 dclo,
   input  lsi_pkg::phase_t     ph,
   input  lsi_pkg::core_bus_t  core,
   input  wire                 set_fdin,
   input  wire                 init_st,
   input  wire                 berr_st,
   input  wire                 aclo_any,
   input  wire  [1:0]          bsel,       // boot mode jumpers
   input  lsi_pkg::qbus_in_t   qin,
   input  wire                 dmgo,       // bus granted to dma master
   output lsi_pkg::qbus_out_t  qout_bus,
   output logic                ra,
   output logic                rply_q,
   output logic [15:0]         ad_rd,
   output logic                cyc_act
);
   import lsi_pkg::*;

   logic sync_q;                           // bus sync, ph3 timed
   logic dout_q;                           // bus dout, ph3 timed
   logic dout_d;                           // dout seen at ph2
   logic iako_q;
   logic fdin_st;                          // fast input read pending
   logic syn_d;                            // syn history for fall detect
   logic ad_en;                            // board owns ad lines
   logic bus_rel;                          // bus given to dma master

   assign bus_rel = qin.sack | dmgo;

   always_ff @(posedge c2 or posedge dclo)
   begin
      if (dclo)
      begin
         sync_q  <= 1'b0;
         dout_q  <= 1'b0;
         dout_d  <= 1'b0;
         rply_q  <= 1'b0;
         iako_q  <= 1'b0;
         fdin_st <= 1'b0;
         syn_d   <= 1'b0;
         ad_en   <= 1'b0;
      end
      else
      begin
         syn_d <= core.syn;
         if (core.inrak)
            sync_q <= 1'b0;                // vector read ends address phase
         else if (ph.ph3)
            sync_q <= core.syn | (sync_q & rply_q);   // hold for slave
         if (~core.syn)
            dout_q <= 1'b0;
         else if (ph.ph3)
            dout_q <= core.dout & ~rply_q;
         if (ph.ph2)
            dout_d <= dout_q;
         if (init_st)
            rply_q <= 1'b0;
         else if (ph.ph1)
            rply_q <= qin.rply;
         if (~core.di)
            iako_q <= 1'b0;
         else if (ph.ph1)
            iako_q <= core.inrak;
         if (syn_d & ~core.syn)
            fdin_st <= 1'b0;               // cleared at end of cycle
         else if (set_fdin)
            fdin_st <= 1'b1;
         // release ad for reads and dma, retake when idle or writing
         if (bus_rel | core.di)
            ad_en <= 1'b0;
         else if (~sync_q | dout_q)
            ad_en <= 1'b1;
      end
   end

   // read path, fast input word or bus data
   assign ad_rd = fdin_st ? {12'h000, aclo_any, berr_st, bsel} : qin.ad;

   assign ra      = rply_q & (dout_d | core.di);
   assign cyc_act = core.di | dout_d;      // timer runs while set

   assign qout_bus.ad      = core.ad;
   assign qout_bus.ad_oe   = ad_en & ~(bus_rel | core.di);   // drop at once
   assign qout_bus.sync    = sync_q;
   assign qout_bus.wtbt    = core.wrby;
   assign qout_bus.dout    = dout_q;
   assign qout_bus.din     = core.di;
   assign qout_bus.ctrl_oe = ~bus_rel;
   assign qout_bus.iako    = iako_q;
   assign qout_bus.init    = 1'b0;         // filled in at top level
   assign qout_bus.dmgo    = 1'b0;
   assign qout_bus.dref    = 1'b0;

endmodule

`default_nettype wire

/* design/lsi_qtimer.sv */
// bus transaction timeout counter
// sticky bus error and abort request
`timescale 1ns/100ps
`default_nettype none

module lsi_qtimer
(
   input  wire              c2,
   input  wire              dclo,
   input  lsi_pkg::phase_t  ph,
   input  wire              cyc_act,    // din or dout_d
   input  wire              init_st,
   input  wire              clr_berr,
   output logic             berr_st,
   output logic             berr_rq
);
   import lsi_pkg::*;

   logic [5:0] qtim;                      // counts ph3 periods
   logic       qtim_to;                   // limit reached

   assign qtim_to = (qtim == QTIM_MAX);

   always_ff @(posedge c2 or posedge dclo)
   begin
      if (dclo)
      begin
         qtim    <= 6'd0;
         berr_st <= 1'b0;
      end
      else
      begin
         if (~cyc_act)
            qtim <= 6'd0;                 // restart for next cycle
         else if (ph.ph3 & ~qtim_to)
            qtim <= qtim + 6'd1;
         if (init_st | clr_berr)
            berr_st <= 1'b0;
         else if (cyc_act & ph.ph3 & (qtim == QTIM_MAX - 6'd1))
            berr_st <= 1'b1;              // set on the step into the limit
      end
   end

   assign berr_rq = berr_st & cyc_act & qtim_to;   // abort stuck cycle

endmodule

`default_nettype wire

/* design/lsi_dma.sv */
// Q-bus DMA arbitration
// request, acknowledge, grant and refresh-during-dma flag
`timescale 1ns/100ps
`default_nettype none

module lsi_dma
(
   input  wire              c2,
   input  wire              dclo,
   input  lsi_pkg::phase_t  ph,
   input  wire              sack,       // master acknowledge
   input  wire              dmr,        // dma request line
   input  wire              syn,        // chipset sync, ends the grant
   input  wire              init_st,
   input  wire              dref_rq,
   input  wire              dref_st,
   input  wire              rply_q,
   output logic             dmgo,
   output logic             bbusy
);
   import lsi_pkg::*;

   logic dmr_q;                           // request register
   logic dmr_rf;                          // refresh came in during last dma
   logic sack_q;                          // ack seen at ph4
   logic sack_d;

   always_ff @(posedge c2 or posedge dclo)
   begin
      if (dclo)
      begin
         dmr_q  <= 1'b0;
         dmr_rf <= 1'b0;
         sack_q <= 1'b0;
         sack_d <= 1'b0;
         dmgo   <= 1'b0;
      end
      else
      begin
         sack_d <= sack;
         if (init_st)
            dmr_q <= 1'b0;
         else if (sack)
            dmr_q <= 1'b1;                // master holds bus
         else if (ph.ph1)
            dmr_q <= dmr & ~dmr_rf;       // let refresh in first
         if (syn)
            dmr_rf <= 1'b0;
         else if (sack_d & ~sack)
            dmr_rf <= dref_rq & dref_st;  // sampled as master leaves
         if (~dmr_q)
            sack_q <= 1'b0;
         else if (ph.ph4)
            sack_q <= sack;
         if (syn)
            dmgo <= 1'b0;
         else if (ph.ph4)
            dmgo <= sack_q;               // one ph4 behind the ack
      end
   end

   assign bbusy = dmr_q | rply_q;

endmodule

`default_nettype wire

/* design/lsi_board.sv */
// top level of the processor card board logic
// phase sequencer, events, Q-bus cycle, bus timer, DMA arbiter
`timescale 1ns/100ps
`default_nettype none

module lsi_board
(
   input  wire                 c2,
   input  wire                 dclo,
   input  lsi_pkg::core_bus_t  core,      // chipset bus side
   input  lsi_pkg::mc_code_t   mc,
   input  lsi_pkg::qbus_in_t   qin,
   input  wire                 aclo,
   input  wire                 evnt,
   input  wire                 halt,
   input  wire                 virq,
   input  wire  [1:0]          bsel,
   output lsi_pkg::core_ctl_t  core_ctl,
   output lsi_pkg::qbus_out_t  qout
);
   import lsi_pkg::*;

   phase_t     ph;
   logic       clr_init, clr_berr, set_rfsh, set_init;
   logic       set_fdin, clr_aclo, clr_evnt;
   logic       init_st, dref_st, dref_rq, aclo_any;
   logic [3:0] inrrq;
   logic       sr, ra, rply_q, cyc_act;
   logic [15:0] ad_rd;
   logic       berr_st, berr_rq;
   logic       dmgo, bbusy;
   qbus_out_t  qbus_o;                     // cycle fields from lsi_qbus

   lsi_sequencer seq_i (
      .c2, .dclo, .mc, .ph,
      .clr_init, .clr_berr, .set_rfsh, .set_init,
      .set_fdin, .clr_aclo, .clr_evnt
   );

   lsi_events evt_i (
      .c2, .dclo, .ph,
      .clr_init, .set_init, .set_rfsh, .clr_berr, .clr_aclo, .clr_evnt,
      .aclo, .evnt, .halt, .virq, .rfrq(qin.rfrq), .berr_rq,
      .inrrq, .sr, .init_st, .dref_st, .dref_rq, .aclo_any
   );

   lsi_qbus qbus_i (
      .c2, .dclo, .ph, .core, .set_fdin, .init_st, .berr_st, .aclo_any,
      .bsel, .qin, .dmgo, .qout_bus(qbus_o),
      .ra, .rply_q, .ad_rd, .cyc_act
   );

   lsi_qtimer qtim_i (
      .c2, .dclo, .ph, .cyc_act, .init_st, .clr_berr, .berr_st, .berr_rq
   );

   lsi_dma dma_i (
      .c2, .dclo, .ph, .sack(qin.sack), .dmr(qin.dmr), .syn(core.syn),
      .init_st, .dref_rq, .dref_st, .rply_q, .dmgo, .bbusy
   );

   assign qout = '{ad: qbus_o.ad, ad_oe: qbus_o.ad_oe, sync: qbus_o.sync,
                   wtbt: qbus_o.wtbt, dout: qbus_o.dout, din: qbus_o.din,
                   ctrl_oe: qbus_o.ctrl_oe, iako: qbus_o.iako,
                   init: init_st, dmgo: dmgo, dref: dref_st};

   assign core_ctl = '{inrrq: inrrq, bbusy: bbusy, sr: sr, ra: ra, ad_rd: ad_rd};

endmodule

`default_nettype wire

/* testbench/lsi_board_tb.sv */
// testbench for the board logic, plays chipset and Q-bus
// table of rows: strobes, interrupt edges, write, read, fast read, timeout, dma
`timescale 1ns/100ps
`default_nettype none

module lsi_board_tb;
   import lsi_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int N_ROWS     = 18;
   localparam int SR_WAIT    = (int'(QTIM_MAX) + 1) * 4;   // cycles to abort
   localparam logic [2:0] K_STROBE = 3'd0, K_EDGE = 3'd1, K_WRITE = 3'd2, K_READ = 3'd3;
   localparam logic [2:0] K_FAST = 3'd4, K_TIMEOUT = 3'd5, K_DMA = 3'd6;

   typedef struct packed {
      logic [2:0]  kind;
      mc_code_t    mc;                    // strobe code of the row
      logic [15:0] data;                  // bus word or input select
      logic [1:0]  bsel;
      logic [15:0] expected;
   } row_t;

   logic c2, dclo, aclo, evnt, halt, virq;
   logic [1:0] bsel;
   core_bus_t  core;
   mc_code_t   mc;
   qbus_in_t   qin;
   core_ctl_t  core_ctl;
   qbus_out_t  qout;

   row_t        rows [N_ROWS];
   string       names [N_ROWS];
   int          n_rows, n_checks, n_errors;
   int          ph_cur;                   // phase active in this cycle, 0 before ph1
   logic [31:0] lfsr;

   lsi_board dut_i (
      .c2, .dclo, .core, .mc, .qin, .aclo, .evnt, .halt, .virq, .bsel,
      .core_ctl, .qout
   );

   always #(CLK_PERIOD / 2) c2 = ~c2;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // galois taps
   endfunction

   task automatic draw_word(output logic [15:0] w);
      for (int b = 0; b < 16; b++)
      begin
         lfsr = lfsr_next(lfsr);          // one step per bit
         w = {w[14:0], lfsr[0]};
      end
   endtask

   task automatic compare_word(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
      n_checks++;
      assert (act == exp)
      else
      begin
         n_errors++;
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic require(input logic cond, input string what);
      n_checks++;
      assert (cond)
      else
      begin
         n_errors++;
         $display("error: %s", what);
      end
   endtask

   task automatic next_cycle;
      @(posedge c2);
      ph_cur = (ph_cur == 4) ? 1 : ph_cur + 1;
   endtask

   task automatic goto_phase(input int p);   // always moves at least one cycle
      next_cycle;
      while (ph_cur != p)
         next_cycle;
   endtask

   task automatic settle;
      @(negedge c2);                      // outputs stable mid cycle
   endtask

   task automatic end_cycle;
      next_cycle;
      core.syn  <= 1'b0;
      core.di   <= 1'b0;
      core.dout <= 1'b0;
      core.wrby <= 1'b0;
      qin.rply  <= 1'b0;
      goto_phase(4);
      goto_phase(4);                      // let flags drain
   endtask

   task automatic read_fast(output logic [15:0] word);
      goto_phase(3);
      mc <= MC_SET_FDIN;
      next_cycle;
      mc <= 4'b0000;
      settle;
      word = core_ctl.ad_rd;
   endtask

   task automatic add_row(input string name, input logic [2:0] kind, input mc_code_t code,
                          input logic [15:0] data, input logic [1:0] bs,
                          input logic [15:0] exp);
      rows[n_rows]  = '{kind: kind, mc: code, data: data, bsel: bs, expected: exp};
      names[n_rows] = name;
      n_rows++;
   endtask

   task automatic build_table;
      logic [15:0] w;
      // strobe rows expect {init, dref}
      add_row("nop_1000", K_STROBE, 4'b1000, 16'h0, 2'b00, 16'h0002);
      add_row("clr_init", K_STROBE, 4'b1001, 16'h0, 2'b00, 16'h0000);
      add_row("set_rfsh", K_STROBE, 4'b1011, 16'h0, 2'b00, 16'h0001);
      add_row("set_init", K_STROBE, 4'b1100, 16'h0, 2'b00, 16'h0003);
      add_row("nop_0111", K_STROBE, 4'b0111, 16'h0, 2'b00, 16'h0003);
      add_row("clr_berr", K_STROBE, 4'b1010, 16'h0, 2'b00, 16'h0002);
      add_row("clr_init2", K_STROBE, 4'b1001, 16'h0, 2'b00, 16'h0000);
      // edge rows, data bit 0 virq, 1 evnt, 2 aclo
      add_row("evnt_edge", K_EDGE, 4'b1111, 16'h0002, 2'b00, 16'h0002);
      add_row("aclo_edge", K_EDGE, 4'b1110, 16'h0004, 2'b00, 16'h0004);
      add_row("virq_level", K_EDGE, 4'b0000, 16'h0001, 2'b00, 16'h0001);
      draw_word(w);
      add_row("write_a", K_WRITE, 4'b0000, w, 2'b00, w);
      draw_word(w);
      add_row("write_b", K_WRITE, 4'b0000, w, 2'b00, w);
      draw_word(w);
      add_row("read_a", K_READ, 4'b0000, w, 2'b00, w);
      draw_word(w);
      add_row("read_b", K_READ, 4'b0000, w, 2'b00, w);
      // fast read word is {aclo, berr, bsel}
      add_row("fast_rd_a", K_FAST, 4'b1101, 16'h0, 2'b01, 16'h0001);
      add_row("fast_rd_b", K_FAST, 4'b1101, 16'h0, 2'b10, 16'h0002);
      add_row("timeout", K_TIMEOUT, 4'b1010, 16'h0, 2'b11, 16'h0007);
      add_row("dma_grant", K_DMA, 4'b0000, 16'h0, 2'b00, 16'h0001);
   endtask

   task automatic apply_strobe(input int i);
      goto_phase(3);
      mc <= rows[i].mc;                   // code present in ph3
      next_cycle;
      mc <= 4'b0000;
      settle;
      compare_word(names[i], rows[i].expected, {14'd0, qout.init, qout.dref});
   endtask

   task automatic pulse_edge(input int i);
      logic [2:0] sel;
      sel = rows[i].data[2:0];
      next_cycle;
      virq <= sel[0];
      evnt <= sel[1];
      aclo <= sel[2];
      next_cycle;
      evnt <= 1'b0;                       // edges fall, requests must stay
      aclo <= 1'b0;
      goto_phase(3);                      // past a ph2 latch
      settle;
      compare_word(names[i], rows[i].expected, {12'd0, core_ctl.inrrq});
      goto_phase(3);
      mc   <= rows[i].mc;                 // matching clear
      virq <= 1'b0;
      next_cycle;
      mc <= 4'b0000;
      goto_phase(3);
      settle;
      compare_word({names[i], "_clr"}, 16'h0000, {12'd0, core_ctl.inrrq});
   endtask

   task automatic write_cycle(input int i);
      next_cycle;
      core.ad   <= rows[i].data;
      core.syn  <= 1'b1;
      core.dout <= 1'b1;
      core.wrby <= 1'b1;
      goto_phase(4);                      // sync and dout taken at ph3
      settle;
      compare_word(names[i], rows[i].expected, qout.ad);
      require(qout.sync & qout.dout & qout.wtbt & qout.ad_oe,
              "write cycle did not drive sync, dout, wtbt and ad");
      goto_phase(1);
      qin.rply <= 1'b1;
      goto_phase(3);
      settle;
      compare_word({names[i], "_ra"}, 16'h0001, {15'd0, core_ctl.ra});
      end_cycle;
   endtask

   task automatic read_cycle(input int i);
      next_cycle;
      qin.ad   <= rows[i].data;
      core.syn <= 1'b1;
      core.di  <= 1'b1;
      next_cycle;
      settle;
      compare_word(names[i], rows[i].expected, core_ctl.ad_rd);
      require(~qout.ad_oe & qout.din, "ad_oe still set while din is active");
      next_cycle;
      qin.rply <= 1'b1;
      goto_phase(2);                      // rply registered at ph1
      settle;
      compare_word({names[i], "_ra"}, 16'h0001, {15'd0, core_ctl.ra});
      end_cycle;
   endtask

   task automatic fast_read_row(input int i);
      logic [15:0] word;
      next_cycle;
      bsel     <= rows[i].bsel;
      qin.ad   <= ~rows[i].expected;      // bus data must not show
      core.syn <= 1'b1;
      core.di  <= 1'b1;
      read_fast(word);
      compare_word(names[i], rows[i].expected, word);
      end_cycle;
   endtask

   task automatic timeout_cycle(input int i);
      logic [15:0] word;
      int n;
      next_cycle;
      bsel     <= rows[i].bsel;
      core.syn <= 1'b1;
      core.di  <= 1'b1;                   // no rply follows
      n = 0;
      settle;
      while (!core_ctl.sr && n < SR_WAIT)
      begin
         next_cycle;
         settle;
         n++;
      end
      require(core_ctl.sr, "bus timeout did not raise sr in time");
      read_fast(word);
      compare_word(names[i], rows[i].expected, word);
      end_cycle;
      goto_phase(3);
      mc <= rows[i].mc;                   // clr_berr
      next_cycle;
      mc <= 4'b0000;
      core.syn <= 1'b1;
      core.di  <= 1'b1;
      read_fast(word);
      compare_word({names[i], "_clr"}, rows[i].expected & ~16'h0004, word);
      end_cycle;
      settle;
      compare_word({names[i], "_sr"}, 16'h0000, {15'd0, core_ctl.sr});
   endtask

   task automatic dma_grant(input int i);
      int n;
      next_cycle;
      qin.dmr  <= 1'b1;
      qin.sack <= 1'b1;
      next_cycle;
      settle;
      require(~qout.ctrl_oe, "ctrl_oe not dropped while sack is set");
      n = 0;
      while (!qout.dmgo && n < 12)        // two ph4 periods and margin
      begin
         next_cycle;
         settle;
         n++;
      end
      compare_word(names[i], rows[i].expected, {15'd0, qout.dmgo});
      compare_word({names[i], "_bbusy"}, 16'h0001, {15'd0, core_ctl.bbusy});
      next_cycle;
      core.syn <= 1'b1;
      next_cycle;
      settle;
      compare_word({names[i], "_syn"}, 16'h0000, {15'd0, qout.dmgo});
      next_cycle;
      qin.sack <= 1'b0;
      qin.dmr  <= 1'b0;
      goto_phase(2);
      goto_phase(2);                      // hold syn past the next ph4
      end_cycle;
   endtask

   initial
   begin
      c2 = 1'b0;
      dclo = 1'b1;
      core = '0;
      mc = 4'b0000;
      qin = '0;
      aclo = 1'b0;
      evnt = 1'b0;
      halt = 1'b0;
      virq = 1'b0;
      bsel = 2'b00;
      n_rows = 0;
      n_checks = 0;
      n_errors = 0;
      ph_cur = 0;
      lfsr = 32'h0f7b8aa3;
      build_table;
      repeat (4) @(posedge c2);
      dclo <= 1'b0;
      ph_cur = 0;                         // next edge starts ph1
      settle;
      compare_word("reset_state", 16'h0600,
                   {5'd0, qout.init, core_ctl.sr, qout.sync, qout.dout, qout.iako,
                    qout.dmgo, qout.dref, core_ctl.inrrq});
      for (int i = 0; i < n_rows; i++)
      begin
         case (rows[i].kind)
            K_STROBE:  apply_strobe(i);
            K_EDGE:    pulse_edge(i);
            K_WRITE:   write_cycle(i);
            K_READ:    read_cycle(i);
            K_FAST:    fast_read_row(i);
            K_TIMEOUT: timeout_cycle(i);
            default:   dma_grant(i);
         endcase
      end
      $display("checks run: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

   // watchdog, 400 cycles per table row
   initial
   begin
      #(N_ROWS * 400 * CLK_PERIOD);
      $display("watchdog expired before the table finished");
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

/* lsi_board.f */
design/lsi_pkg.sv
design/lsi_sequencer.sv
design/lsi_events.sv
design/lsi_qbus.sv
design/lsi_qtimer.sv
design/lsi_dma.sv
design/lsi_board.sv
testbench/lsi_board_tb.sv

/* run_lsi_board.sh */
#!/usr/bin/env bash
# build the board logic testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
LOG=sim_lsi_board.log

verilator --binary --timing --assert -f lsi_board.f --top-module lsi_board_tb \
   -o lsi_board_sim > "$LOG" 2>&1 \
   && ./obj_dir/lsi_board_sim >> "$LOG" 2>&1 \
   || { echo "build or simulation run failed, see $LOG"; exit 1; }

grep -q "ERRORS FOUND" "$LOG" && { echo "simulation reported failures, see $LOG"; exit 1; }
grep -q "NO ERRORS" "$LOG" || { echo "simulation ended without a result, see $LOG"; exit 1; }
echo "simulation passed"
exit 0
